/* hdl/fpga_boot_cfg.svh */
// board management constants

`ifndef FPGA_BOOT_CFG_SVH
`define FPGA_BOOT_CFG_SVH

// core reset stretch after reset and lock are both seen high
`define FPGA_BOOT_RST_STAGES 4

// depth of every input synchronizer
`define FPGA_BOOT_SYNC_STAGES 2

// configuration port command words, before per-byte bit reversal

// dummy pad word
`define FPGA_BOOT_CFG_DUMMY 32'hFFFF_FFFF

// sync word, starts packet processing
`define FPGA_BOOT_CFG_SYNC 32'hAA99_5566

// type 1 no-op
`define FPGA_BOOT_CFG_NOOP 32'h2000_0000

// type 1 write of one word to the command register
`define FPGA_BOOT_CFG_WR_CMD 32'h3000_8001

// IPROG command, reloads the bitstream from flash
`define FPGA_BOOT_CFG_IPROG 32'h0000_000F

`endif

/* hdl/fpga_boot_pkg.sv */
// board management types

package fpga_boot_pkg;

    // one configuration port word
    typedef logic [31:0] cfg_word_t;

    // flash data lanes
    typedef logic [3:0] qspi_dq_t;

    // configuration port command bundle
    // di is already bit-reversed within each byte
    typedef struct packed {
        logic      csib;
        logic      rdwrb;
        cfg_word_t di;
    } icap_cmd_t;

    // flash controller pins, cs is active low
    typedef struct packed {
        logic     sck;
        logic     cs;
        qspi_dq_t dq_o;
        qspi_dq_t dq_oe;
    } qspi_ctrl_t;

    // reboot sequencer, one state per command word on the port
    typedef enum logic [2:0] {
        st_idle,
        st_dummy,
        st_sync,
        st_noop0,
        st_cmd,
        st_iprog,
        st_noop1
    } reboot_state_t;

endpackage

/* hdl/reset_sync.sv */
// core reset conditioner

`timescale 1ns/1ps

`include "fpga_boot_cfg.svh"

module reset_sync (
    input  logic clk_125mhz_int,
    input  logic rst_n,
    input  logic pll_locked,
    output logic core_rst_n
);

    // ones shift in from the bottom once reset and lock are both high
    logic [`FPGA_BOOT_RST_STAGES-1:0] rst_shift;

    // any low input clears the whole chain on the next edge
    // so a single-cycle lock glitch restarts the full release count
    always_ff @(posedge clk_125mhz_int) begin
        if (!rst_n || !pll_locked) begin
            rst_shift <= '0;
        end else begin
            rst_shift <= {rst_shift[`FPGA_BOOT_RST_STAGES-2:0], 1'b1};
        end
    end

    // last stage is the core reset
    // high on the RST_STAGES-th edge counting the first edge that saw both high
    assign core_rst_n = rst_shift[`FPGA_BOOT_RST_STAGES-1];

endmodule

/* hdl/icap_reboot_seq.sv */
// configuration port reboot sequencer

`timescale 1ns/1ps

`include "fpga_boot_cfg.svh"

module icap_reboot_seq (
    input  logic                   clk_125mhz_int,
    input  logic                   rst_n,
    input  logic                   fpga_boot,
    input  logic                   icap_avail,
    output fpga_boot_pkg::icap_cmd_t icap_cmd
);

    import fpga_boot_pkg::*;

    // boot request synchronizer
    logic [`FPGA_BOOT_SYNC_STAGES-1:0] boot_sync;
    logic                              boot_req;

    reboot_state_t state;
    logic          csib;
    cfg_word_t     di_word;
    cfg_word_t     di_rev;

    always_ff @(posedge clk_125mhz_int) begin
        if (!rst_n) begin
            boot_sync <= '0;
        end else begin
            boot_sync <= {boot_sync[`FPGA_BOOT_SYNC_STAGES-2:0], fpga_boot};
        end
    end

    assign boot_req = boot_sync[`FPGA_BOOT_SYNC_STAGES-1];

    // state names the word currently registered on the port
    // avail only matters in idle, a running sequence always completes
    always_ff @(posedge clk_125mhz_int) begin
        if (!rst_n) begin
            state   <= st_idle;
            csib    <= 1'b1;
            di_word <= `FPGA_BOOT_CFG_DUMMY;
        end else begin
            case (state)
                st_idle: begin
                    csib    <= 1'b1;
                    di_word <= `FPGA_BOOT_CFG_DUMMY;
                    if (boot_req && icap_avail) begin
                        state <= st_dummy;
                        csib  <= 1'b0;
                    end
                end
                st_dummy: begin
                    state   <= st_sync;
                    di_word <= `FPGA_BOOT_CFG_SYNC;
                end
                st_sync: begin
                    state   <= st_noop0;
                    di_word <= `FPGA_BOOT_CFG_NOOP;
                end
                st_noop0: begin
                    state   <= st_cmd;
                    di_word <= `FPGA_BOOT_CFG_WR_CMD;
                end
                st_cmd: begin
                    state   <= st_iprog;
                    di_word <= `FPGA_BOOT_CFG_IPROG;
                end
                st_iprog: begin
                    state   <= st_noop1;
                    di_word <= `FPGA_BOOT_CFG_NOOP;
                end
                // back to idle with the port deselected for at least a cycle
                default: begin
                    state   <= st_idle;
                    csib    <= 1'b1;
                    di_word <= `FPGA_BOOT_CFG_DUMMY;
                end
            endcase
        end
    end

    // port takes each byte msb-first on the low lane
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            for (int i = 0; i < 8; i++) begin
                di_rev[8*b+i] = di_word[8*b+7-i];
            end
        end
    end

    assign icap_cmd.csib  = csib;
    // write only, readback is never used
    assign icap_cmd.rdwrb = 1'b0;
    assign icap_cmd.di    = di_rev;

endmodule

/* hdl/qspi_pad_reg.sv */
// flash pad stage

`timescale 1ns/1ps

`include "fpga_boot_cfg.svh"

module qspi_pad_reg (
    input  logic                     clk_125mhz_int,
    input  logic                     rst_n,
    input  fpga_boot_pkg::qspi_ctrl_t qspi_ctrl,
    output fpga_boot_pkg::qspi_ctrl_t qspi_pad,
    input  fpga_boot_pkg::qspi_dq_t   qspi_dq_pad,
    output fpga_boot_pkg::qspi_dq_t   qspi_dq_i
);

    import fpga_boot_pkg::*;

    // clock low, flash deselected, data lanes released
    localparam qspi_ctrl_t pad_idle = '{sck: 1'b0, cs: 1'b1, dq_o: '0, dq_oe: '0};

    // incoming lanes, index 0 faces the pads
    qspi_dq_t dq_sync [`FPGA_BOOT_SYNC_STAGES];

    // outputs go through one pad flop each
    always_ff @(posedge clk_125mhz_int) begin
        if (!rst_n) begin
            qspi_pad <= pad_idle;
        end else begin
            qspi_pad <= qspi_ctrl;
        end
    end

    always_ff @(posedge clk_125mhz_int) begin
        if (!rst_n) begin
            for (int i = 0; i < `FPGA_BOOT_SYNC_STAGES; i++) begin
                dq_sync[i] <= '0;
            end
        end else begin
            dq_sync[0] <= qspi_dq_pad;
            for (int i = 1; i < `FPGA_BOOT_SYNC_STAGES; i++) begin
                dq_sync[i] <= dq_sync[i-1];
            end
        end
    end

    assign qspi_dq_i = dq_sync[`FPGA_BOOT_SYNC_STAGES-1];

endmodule

/* hdl/fpga_boot_top.sv */
// board management top level

`timescale 1ns/1ps

module fpga_boot_top (
    // internal 125 MHz clock and board reset
    input  logic                      clk_125mhz_int,
    input  logic                      rst_n,
    input  logic                      pll_locked,

    // reboot request and configuration port
    input  logic                      fpga_boot,
    input  logic                      icap_avail,
    output fpga_boot_pkg::icap_cmd_t  icap_cmd,

    // configuration flash
    input  fpga_boot_pkg::qspi_ctrl_t qspi_ctrl,
    output fpga_boot_pkg::qspi_ctrl_t qspi_pad,
    input  fpga_boot_pkg::qspi_dq_t   qspi_dq_pad,
    output fpga_boot_pkg::qspi_dq_t   qspi_dq_i
);

    // held low until lock, then stretched
    logic core_rst_n;

    reset_sync i_reset_sync (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_n          (rst_n),
        .pll_locked     (pll_locked),
        .core_rst_n     (core_rst_n)
    );

    // the sequencer and the pad stage only run on the conditioned reset
    icap_reboot_seq i_icap_reboot_seq (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_n          (core_rst_n),
        .fpga_boot      (fpga_boot),
        .icap_avail     (icap_avail),
        .icap_cmd       (icap_cmd)
    );

    qspi_pad_reg i_qspi_pad_reg (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_n          (core_rst_n),
        .qspi_ctrl      (qspi_ctrl),
        .qspi_pad       (qspi_pad),
        .qspi_dq_pad    (qspi_dq_pad),
        .qspi_dq_i      (qspi_dq_i)
    );

endmodule

/* dv/fpga_boot_props.sv */
// board management properties

`timescale 1ns/1ps

module fpga_boot_props (
    input logic                      clk_125mhz_int,
    input logic                      core_rst_n,
    input fpga_boot_pkg::icap_cmd_t  icap_cmd,
    input fpga_boot_pkg::qspi_ctrl_t qspi_pad
);

    // bumped on every property failure, read back by the testbench
    int unsigned fail_count;

    // write only port
    assert property (@(posedge clk_125mhz_int) !icap_cmd.rdwrb)
        else begin
            $error("rdwrb went high on the configuration port");
            fail_count++;
        end

    // one reboot run is exactly six selected words
    assert property (@(posedge clk_125mhz_int) disable iff (!core_rst_n)
        $fell(icap_cmd.csib) |-> (!icap_cmd.csib) [*6] ##1 icap_cmd.csib)
        else begin
            $error("csib low run is not six cycles long");
            fail_count++;
        end

    // outputs are registered, so the safe state shows one edge later
    assert property (@(posedge clk_125mhz_int)
        !core_rst_n |=> (icap_cmd.csib && qspi_pad.cs))
        else begin
            $error("port or flash selected while the core is in reset");
            fail_count++;
        end

endmodule

bind fpga_boot_top fpga_boot_props i_fpga_boot_props (
    .clk_125mhz_int (clk_125mhz_int),
    .core_rst_n     (core_rst_n),
    .icap_cmd       (icap_cmd),
    .qspi_pad       (qspi_pad)
);

/* dv/fpga_boot_tb.sv */
// board management testbench

`timescale 1ns/1ps

`include "fpga_boot_cfg.svh"

module fpga_boot_tb;

    import fpga_boot_pkg::*;

    logic       clk_125mhz_int;
    logic       rst_n;
    logic       pll_locked;
    logic       fpga_boot;
    logic       icap_avail;
    icap_cmd_t  icap_cmd;
    qspi_ctrl_t qspi_ctrl;
    qspi_ctrl_t qspi_pad;
    qspi_dq_t   qspi_dq_pad;
    qspi_dq_t   qspi_dq_i;

    // reference model state
    int unsigned                       rst_cnt_m;
    logic                              core_m;
    logic [`FPGA_BOOT_SYNC_STAGES-1:0] boot_sync_m;
    int unsigned                       step_m;
    qspi_ctrl_t                        pad_m;
    qspi_dq_t                          dq_m [`FPGA_BOOT_SYNC_STAGES];

    int unsigned errors;
    int unsigned checks;
    bit          model_check_en;

    fpga_boot_top i_fpga_boot_top (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_n          (rst_n),
        .pll_locked     (pll_locked),
        .fpga_boot      (fpga_boot),
        .icap_avail     (icap_avail),
        .icap_cmd       (icap_cmd),
        .qspi_ctrl      (qspi_ctrl),
        .qspi_pad       (qspi_pad),
        .qspi_dq_pad    (qspi_dq_pad),
        .qspi_dq_i      (qspi_dq_i)
    );

    initial begin
        clk_125mhz_int = 1'b0;
        forever begin
            #4 clk_125mhz_int = ~clk_125mhz_int;
        end
    end

    // bit i of every byte lands on bit 7-i
    function automatic cfg_word_t reverse_bytes(input cfg_word_t w);
        cfg_word_t r;
        for (int b = 0; b < 32; b += 8) begin
            for (int i = 0; i < 8; i++) begin
                r[b + 7 - i] = w[b + i];
            end
        end
        return r;
    endfunction

    // step 0 is idle and steps 1 to 6 are the words of a run
    function automatic cfg_word_t word_for_step(input int unsigned step);
        case (step)
            2: return `FPGA_BOOT_CFG_SYNC;
            3: return `FPGA_BOOT_CFG_NOOP;
            4: return `FPGA_BOOT_CFG_WR_CMD;
            5: return `FPGA_BOOT_CFG_IPROG;
            6: return `FPGA_BOOT_CFG_NOOP;
            default: return `FPGA_BOOT_CFG_DUMMY;
        endcase
    endfunction

    // release counter saturates at the stretch length
    assign core_m = (rst_cnt_m == `FPGA_BOOT_RST_STAGES);

    always @(posedge clk_125mhz_int) begin
        if (!rst_n || !pll_locked) begin
            rst_cnt_m <= 0;
        end else if (rst_cnt_m < `FPGA_BOOT_RST_STAGES) begin
            rst_cnt_m <= rst_cnt_m + 1;
        end
        if (!core_m) begin
            boot_sync_m <= '0;
            step_m      <= 0;
            pad_m       <= '{sck: 1'b0, cs: 1'b1, dq_o: 4'h0, dq_oe: 4'h0};
            for (int i = 0; i < `FPGA_BOOT_SYNC_STAGES; i++) begin
                dq_m[i] <= '0;
            end
        end else begin
            boot_sync_m[0] <= fpga_boot;
            dq_m[0]        <= qspi_dq_pad;
            for (int i = 1; i < `FPGA_BOOT_SYNC_STAGES; i++) begin
                boot_sync_m[i] <= boot_sync_m[i-1];
                dq_m[i]        <= dq_m[i-1];
            end
            if (step_m == 0) begin
                if (boot_sync_m[`FPGA_BOOT_SYNC_STAGES-1] && icap_avail) begin
                    step_m <= 1;
                end
            end else if (step_m == 6) begin
                step_m <= 0;
            end else begin
                step_m <= step_m + 1;
            end
            pad_m <= qspi_ctrl;
        end
    end

    task automatic report_error(input string msg);
        errors++;
        $display("error at time %0t: %s", $time, msg);
    endtask

    task automatic verify(input bit ok, input string msg);
        checks++;
        assert (ok) else report_error(msg);
    endtask

    task automatic compare_with_model();
        cfg_word_t exp_di;
        exp_di = reverse_bytes(word_for_step(step_m));
        verify(i_fpga_boot_top.core_rst_n === core_m,
            $sformatf("core_rst_n is %b, model %b", i_fpga_boot_top.core_rst_n, core_m));
        verify(icap_cmd.csib === (step_m == 0),
            $sformatf("csib is %b in model step %0d", icap_cmd.csib, step_m));
        verify(icap_cmd.rdwrb === 1'b0, "rdwrb is not low");
        verify(icap_cmd.di === exp_di,
            $sformatf("di is %h, model %h", icap_cmd.di, exp_di));
        verify(qspi_pad === pad_m,
            $sformatf("qspi_pad is %h, model %h", qspi_pad, pad_m));
        verify(qspi_dq_i === dq_m[`FPGA_BOOT_SYNC_STAGES-1],
            $sformatf("qspi_dq_i is %h, model %h", qspi_dq_i,
                dq_m[`FPGA_BOOT_SYNC_STAGES-1]));
    endtask

    // outputs and model are both stable mid-cycle
    always @(negedge clk_125mhz_int) begin
        if (model_check_en) begin
            compare_with_model();
        end
    end

    task automatic check_reset_outputs();
        verify(icap_cmd.csib === 1'b1, "csib not high in reset");
        verify(icap_cmd.di === 32'hFFFF_FFFF,
            $sformatf("di is %h in reset, expected all ones", icap_cmd.di));
        verify(qspi_pad.sck === 1'b0, "flash sck not low in reset");
        verify(qspi_pad.cs === 1'b1, "flash cs not high in reset");
        verify(qspi_pad.dq_oe === 4'h0,
            $sformatf("flash dq_oe is %h in reset", qspi_pad.dq_oe));
    endtask

    task automatic wait_core(input logic level, input int unsigned limit,
                             output int unsigned n);
        n = 0;
        do begin
            @(negedge clk_125mhz_int);
            n++;
        end while (i_fpga_boot_top.core_rst_n !== level && n < limit);
        if (i_fpga_boot_top.core_rst_n !== level) begin
            errors++;
            $display("timeout: core reset did not go to %b within %0d cycles", level, limit);
        end
    endtask

    task automatic wait_csib(input logic level, input int unsigned limit,
                             output int unsigned n);
        n = 0;
        do begin
            @(negedge clk_125mhz_int);
            n++;
        end while (icap_cmd.csib !== level && n < limit);
        if (icap_cmd.csib !== level) begin
            errors++;
            $display("timeout: csib did not go to %b within %0d cycles", level, limit);
        end
    endtask

    // called on the first cycle of a run and returns on the idle cycle after it
    task automatic check_sequence_words(input bit toggle_avail);
        cfg_word_t exp_di;
        for (int k = 1; k <= 6; k++) begin
            if (k > 1) begin
                @(negedge clk_125mhz_int);
            end
            if (toggle_avail) begin
                icap_avail = (k == 1) ? 1'b0 : 1'($urandom);
            end
            exp_di = reverse_bytes(word_for_step(k));
            verify(icap_cmd.csib === 1'b0, $sformatf("csib high during word %0d", k));
            verify(icap_cmd.di === exp_di,
                $sformatf("word %0d is %h, expected %h", k, icap_cmd.di, exp_di));
        end
        @(negedge clk_125mhz_int);
        verify(icap_cmd.csib === 1'b1, "csib still low after the sixth word");
        verify(icap_cmd.di === reverse_bytes(`FPGA_BOOT_CFG_DUMMY), "di not dummy in idle");
    endtask

    task automatic end_test(input string name, input int unsigned err_before);
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        int unsigned n;
        int unsigned err0;
        int unsigned hold;
        int unsigned low_cycles;
        int unsigned prop_fails;
        qspi_ctrl_t  ctrl_q [$];
        qspi_dq_t    dq_q [$];

        void'($urandom(32'h24c9));
        rst_n          = 1'b0;
        pll_locked     = 1'b1;
        fpga_boot      = 1'b0;
        icap_avail     = 1'b0;
        qspi_ctrl      = '0;
        qspi_dq_pad    = '0;
        errors         = 0;
        checks         = 0;
        low_cycles     = 0;
        model_check_en = 1'b0;
        repeat (2) @(negedge clk_125mhz_int);
        @(posedge clk_125mhz_int);
        model_check_en = 1'b1;
        @(negedge clk_125mhz_int);

        // reset release and lock glitches
        err0  = errors;
        rst_n = 1'b1;
        wait_core(1'b1, 20, n);
        verify(n == 4, $sformatf("core reset released after %0d edges, expected 4", n));
        for (int d = 0; d < 4; d++) begin
            hold       = $urandom_range(3, 1);
            pll_locked = 1'b0;
            wait_core(1'b0, 5, n);
            verify(n == 1, $sformatf("lock drop seen after %0d edges, expected 1", n));
            for (int h = 1; h < hold; h++) begin
                @(negedge clk_125mhz_int);
                check_reset_outputs();
            end
            pll_locked = 1'b1;
            wait_core(1'b1, 20, n);
            verify(n == 4, $sformatf("relock release after %0d edges, expected 4", n));
        end
        end_test("reset_release", err0);

        // board reset in the middle of a run with the flash pins active
        err0       = errors;
        icap_avail = 1'b1;
        qspi_ctrl  = '{sck: 1'b1, cs: 1'b0, dq_o: 4'hA, dq_oe: 4'hF};
        fpga_boot  = 1'b1;
        @(negedge clk_125mhz_int);
        fpga_boot = 1'b0;
        wait_csib(1'b0, 10, n);
        repeat (2) @(negedge clk_125mhz_int);
        rst_n = 1'b0;
        hold  = $urandom_range(5, 2);
        wait_core(1'b0, 5, n);
        for (int h = 1; h < hold; h++) begin
            @(negedge clk_125mhz_int);
            check_reset_outputs();
        end
        rst_n = 1'b1;
        wait_core(1'b1, 20, n);
        verify(n == 4, $sformatf("reset release after %0d edges, expected 4", n));
        end_test("reset_outputs", err0);

        // boot pulses with the port available
        err0 = errors;
        for (int r = 0; r < 3; r++) begin
            fpga_boot = 1'b1;
            @(negedge clk_125mhz_int);
            fpga_boot = 1'b0;
            wait_csib(1'b0, 10, n);
            verify(n + 1 == 3, $sformatf("csib fell %0d edges after request", n + 1));
            check_sequence_words(1'b0);
            repeat ($urandom_range(4, 1)) @(negedge clk_125mhz_int);
        end
        end_test("reboot_sequence", err0);

        // request held while the port is busy
        err0       = errors;
        icap_avail = 1'b0;
        fpga_boot  = 1'b1;
        repeat (12) begin
            @(negedge clk_125mhz_int);
            verify(icap_cmd.csib === 1'b1, "csib fell while icap_avail was low");
        end
        icap_avail = 1'b1;
        wait_csib(1'b0, 10, n);
        verify(n == 1, $sformatf("csib fell %0d edges after icap_avail, expected 1", n));
        fpga_boot = 1'b0;
        check_sequence_words(1'b1);
        repeat (4) @(negedge clk_125mhz_int);
        end_test("avail_gating", err0);

        // flash pad latencies
        err0 = errors;
        for (int c = 0; c < 200; c++) begin
            qspi_ctrl   = qspi_ctrl_t'(10'($urandom));
            qspi_dq_pad = 4'($urandom);
            ctrl_q.push_back(qspi_ctrl);
            dq_q.push_back(qspi_dq_pad);
            @(negedge clk_125mhz_int);
            verify(qspi_pad === ctrl_q[$],
                $sformatf("qspi_pad is %h, expected %h", qspi_pad, ctrl_q[$]));
            if (dq_q.size() >= 2) begin
                verify(qspi_dq_i === dq_q[$-1],
                    $sformatf("qspi_dq_i is %h, expected %h", qspi_dq_i, dq_q[$-1]));
            end
        end
        end_test("flash_stage", err0);

        // everything random at once against the model
        err0 = errors;
        for (int c = 0; c < 500; c++) begin
            fpga_boot   = ($urandom_range(15, 0) == 0);
            icap_avail  = 1'($urandom);
            qspi_ctrl   = qspi_ctrl_t'(10'($urandom));
            qspi_dq_pad = 4'($urandom);
            @(negedge clk_125mhz_int);
            if (icap_cmd.csib === 1'b0) begin
                low_cycles++;
            end
        end
        verify(low_cycles > 0, "no reboot run started during random traffic");
        end_test("random_traffic", err0);

        prop_fails = i_fpga_boot_top.i_fpga_boot_props.fail_count;
        $display("checks %0d, errors %0d, property failures %0d", checks, errors, prop_fails);
        if (errors == 0 && prop_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+hdl
hdl/fpga_boot_pkg.sv
hdl/reset_sync.sv
hdl/icap_reboot_seq.sv
hdl/qspi_pad_reg.sv
hdl/fpga_boot_top.sv
dv/fpga_boot_props.sv
dv/fpga_boot_tb.sv

/* Makefile */
# Verilator build and run for the board management block

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f build.f \
		--top-module fpga_boot_tb -Mdir obj_dir -o vsim
	./obj_dir/vsim | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
